// ==== include/sprite_consts.svh ====
`ifndef SPRITE_CONSTS_SVH
`define SPRITE_CONSTS_SVH

// Pixel coordinate and colour widths
`define PIX_X_W 7
`define PIX_Y_W 7
`define COLOR_W 16

// Sprite geometry
`define SPRITE_W 50
`define SPRITE_H 58
`define COL_PAIRS 25
`define SPANS_PER_PAIR 8

// FIFO depths and credits
`define IN_DEPTH 4
`define OUT_DEPTH 4
`define OUT_CREDITS 2

////////////////////////////////////////
// RGB565 palette
////////////////////////////////////////

`define RGB_BLACK 16'b00000_000000_00000
`define RGB_PINK 16'b11011_011001_01100
`define RGB_YELLOW 16'b11111_111111_00000
`define RGB_GREEN 16'b00000_111111_00000

`endif

// ==== include/strawberry_spans.svh ====
`ifndef STRAWBERRY_SPANS_SVH
`define STRAWBERRY_SPANS_SVH

// One span slot: first row, last row, colour code
`define SPAN(f, l, c) '{6'(f), 6'(l), sprite_pkg::c}
`define SPAN_NONE '{6'd0, 6'd0, sprite_pkg::CC_NONE}

////////////////////////////////////////
// Strawberry shape
////////////////////////////////////////

// Column pairs 0..24 left to right, spans in priority order
// Some spans are shadowed by earlier ones in the same pair
`define STRAWBERRY_SPANS '{ \
    '{`SPAN(26, 34, CC_BLACK), `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(30, 31, CC_YELLOW), `SPAN(26, 34, CC_PINK), `SPAN(21, 39, CC_BLACK), \
      `SPAN_NONE, `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(23, 24, CC_YELLOW), `SPAN(35, 36, CC_YELLOW), `SPAN(21, 39, CC_PINK), \
      `SPAN(17, 41, CC_BLACK), `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(17, 41, CC_PINK), `SPAN(15, 43, CC_BLACK), `SPAN(9, 10, CC_BLACK), \
      `SPAN_NONE, `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(41, 44, CC_BG), `SPAN(17, 18, CC_YELLOW), `SPAN(32, 33, CC_YELLOW), \
      `SPAN(41, 42, CC_YELLOW), `SPAN(15, 43, CC_PINK), `SPAN(13, 46, CC_BLACK), \
      `SPAN(9, 10, CC_BLACK), `SPAN_NONE}, \
    '{`SPAN(38, 41, CC_BG), `SPAN(26, 27, CC_YELLOW), `SPAN(9, 10, CC_GREEN), \
      `SPAN(15, 46, CC_PINK), `SPAN(12, 12, CC_BG), `SPAN(7, 48, CC_BLACK), \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(36, 38, CC_BG), `SPAN(14, 15, CC_YELLOW), `SPAN(43, 44, CC_YELLOW), \
      `SPAN(9, 10, CC_GREEN), `SPAN(13, 48, CC_PINK), `SPAN(7, 50, CC_BLACK), \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(34, 36, CC_BG), `SPAN(20, 21, CC_YELLOW), `SPAN(32, 33, CC_YELLOW), \
      `SPAN(38, 39, CC_YELLOW), `SPAN(49, 50, CC_YELLOW), `SPAN(9, 10, CC_GREEN), \
      `SPAN(13, 48, CC_PINK), `SPAN(7, 52, CC_BLACK)}, \
    '{`SPAN(31, 34, CC_BG), `SPAN(10, 11, CC_GREEN), `SPAN(13, 52, CC_PINK), \
      `SPAN(9, 54, CC_BLACK), `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(29, 31, CC_BG), `SPAN(25, 26, CC_YELLOW), `SPAN(44, 45, CC_YELLOW), \
      `SPAN(11, 12, CC_GREEN), `SPAN(18, 53, CC_PINK), `SPAN(9, 55, CC_BLACK), \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(26, 29, CC_BG), `SPAN(13, 17, CC_GREEN), `SPAN(21, 53, CC_PINK), \
      `SPAN(9, 55, CC_BLACK), `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(24, 27, CC_BG), `SPAN(29, 30, CC_YELLOW), `SPAN(35, 36, CC_YELLOW), \
      `SPAN(51, 52, CC_YELLOW), `SPAN(11, 20, CC_GREEN), `SPAN(23, 54, CC_PINK), \
      `SPAN(9, 57, CC_BLACK), `SPAN_NONE}, \
    '{`SPAN(21, 24, CC_BG), `SPAN(41, 42, CC_YELLOW), `SPAN(11, 22, CC_GREEN), \
      `SPAN(25, 53, CC_PINK), `SPAN(5, 55, CC_BLACK), `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(19, 21, CC_BG), `SPAN(25, 26, CC_YELLOW), `SPAN(46, 47, CC_YELLOW), \
      `SPAN(11, 20, CC_GREEN), `SPAN(23, 53, CC_PINK), `SPAN(5, 8, CC_BG), \
      `SPAN(2, 55, CC_BLACK), `SPAN_NONE}, \
    '{`SPAN(17, 19, CC_BG), `SPAN(31, 32, CC_YELLOW), `SPAN(13, 17, CC_GREEN), \
      `SPAN(21, 52, CC_PINK), `SPAN(2, 8, CC_BG), `SPAN(0, 54, CC_BLACK), \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(15, 17, CC_BG), `SPAN(20, 21, CC_YELLOW), `SPAN(38, 39, CC_YELLOW), \
      `SPAN(48, 49, CC_YELLOW), `SPAN(11, 12, CC_GREEN), `SPAN(18, 50, CC_PINK), \
      `SPAN(9, 52, CC_BLACK), `SPAN_NONE}, \
    '{`SPAN(13, 16, CC_BG), `SPAN(15, 16, CC_YELLOW), `SPAN(23, 24, CC_YELLOW), \
      `SPAN(11, 12, CC_GREEN), `SPAN(14, 48, CC_PINK), `SPAN(9, 50, CC_BLACK), \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(11, 13, CC_BG), `SPAN(33, 34, CC_YELLOW), `SPAN(9, 12, CC_GREEN), \
      `SPAN(14, 46, CC_PINK), `SPAN(7, 48, CC_BLACK), `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(18, 19, CC_YELLOW), `SPAN(43, 44, CC_YELLOW), `SPAN(9, 12, CC_GREEN), \
      `SPAN(14, 46, CC_PINK), `SPAN(7, 48, CC_BLACK), `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(27, 28, CC_YELLOW), `SPAN(36, 37, CC_YELLOW), `SPAN(9, 10, CC_GREEN), \
      `SPAN(15, 44, CC_PINK), `SPAN(7, 46, CC_BLACK), `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(20, 21, CC_YELLOW), `SPAN(15, 41, CC_PINK), `SPAN(11, 12, CC_BG), \
      `SPAN(9, 44, CC_BLACK), `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(29, 30, CC_YELLOW), `SPAN(17, 39, CC_PINK), `SPAN(11, 14, CC_BG), \
      `SPAN(9, 41, CC_BLACK), `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(34, 35, CC_YELLOW), `SPAN(21, 37, CC_PINK), `SPAN(17, 39, CC_BLACK), \
      `SPAN_NONE, `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(25, 26, CC_YELLOW), `SPAN(27, 33, CC_PINK), `SPAN(21, 37, CC_BLACK), \
      `SPAN_NONE, `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE}, \
    '{`SPAN(25, 33, CC_BLACK), `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE, `SPAN_NONE, \
      `SPAN_NONE, `SPAN_NONE} \
}

`endif

// ==== sim.f ====
+incdir+include
verilog/sprite_pkg.sv
verilog/pixel_ingress.sv
verilog/sprite_shader.sv
verilog/pixel_egress.sv
verilog/strawberry_sprite_top.sv
tb/strawberry_chk.sv
tb/strawberry_tb.sv

// ==== tb/strawberry_chk.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"

module strawberry_chk
#(
    parameter int CNT_W = 3,
    parameter int CREDIT_W = 3
)
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   pxValid,
    input  logic [CNT_W-1:0]       count,
    input  logic [CNT_W-1:0]       inFlight,
    input  logic [CREDIT_W-1:0]    credits
);

    // Every beat spends a downstream credit
    assert property (@(posedge clk) disable iff (!arstN) credits <= `OUT_CREDITS)
        else $error("Egress credit count above the downstream grant");

    // Reservations keep the FIFO from overflowing
    assert property (@(posedge clk) disable iff (!arstN) pxValid |-> (count < `OUT_DEPTH))
        else $error("Colour written into a full egress FIFO");

    assert property (@(posedge clk) disable iff (!arstN)
        (count + inFlight) <= `OUT_DEPTH)
        else $error("Egress FIFO and shader hold more pixels than the FIFO depth");

endmodule

bind pixel_egress strawberry_chk #(.CNT_W(CNT_W), .CREDIT_W(CREDIT_W)) chk
(
    .clk(clk),
    .arstN(arstN),
    .pxValid(pxValid),
    .count(count),
    .inFlight(inFlight),
    .credits(credits)
);

// ==== tb/strawberry_tb.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"
`include "strawberry_spans.svh"

module strawberry_tb;

    localparam int NUM_PIXELS = 2000;
    localparam int STALL_COUNT = 5;
    localparam int STALL_SPACING = 400;
    localparam int STALL_SETTLE = 40;
    // About nine cycles per pixel plus the longest possible stalls
    localparam int TIMEOUT_CYCLES = NUM_PIXELS * 9 + STALL_COUNT * 250;

    localparam sprite_pkg::span_t SPAN_TABLE [`COL_PAIRS][`SPANS_PER_PAIR] = `STRAWBERRY_SPANS;

    logic clk;
    logic arstN;
    logic inValid;
    logic [`PIX_X_W-1:0] inX;
    logic [`PIX_Y_W-1:0] inY;
    logic [`PIX_X_W-1:0] inLeftX;
    logic [`PIX_Y_W-1:0] inTopY;
    logic [`COLOR_W-1:0] inBackground;
    logic inCredit;
    logic outValid;
    logic [`COLOR_W-1:0] outColor;
    logic outCredit;

    logic running;
    int unsigned lcgState;
    int sentCount;
    int recvCount;
    int creditPulses;
    int returnedCredits;
    int cycleCount;
    int stallLeft;
    int stallAge;
    int stallsDone;
    int nextStallAt;
    logic [`COLOR_W-1:0] expQ [$];
    // Index 0 outside the box, 1 no span hit, then one per colour code
    bit seen [7];

    strawberry_sprite_top uut
    (
        .clk(clk),
        .arstN(arstN),
        .inValid(inValid),
        .inX(inX),
        .inY(inY),
        .inLeftX(inLeftX),
        .inTopY(inTopY),
        .inBackground(inBackground),
        .inCredit(inCredit),
        .outValid(outValid),
        .outColor(outColor),
        .outCredit(outCredit)
    );

    always #2 clk = ~clk;

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 8;
    endfunction

    function automatic int senderCredits();
        return `IN_DEPTH + creditPulses - sentCount;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // -1 outside the box, else the first matching colour code
    function automatic int classify(int x, int y, int leftX, int topY);
        int col;
        int row;
        int code;
        col = x - leftX;
        row = y - topY;
        if (col < 0 || col >= `SPRITE_W || row < 0 || row >= `SPRITE_H)
            return -1;
        code = int'(sprite_pkg::CC_NONE);
        // Walk backwards so the earliest hit is written last
        for (int i = `SPANS_PER_PAIR - 1; i >= 0; i--)
        begin
            if (SPAN_TABLE[col / 2][i].color != sprite_pkg::CC_NONE &&
                row >= SPAN_TABLE[col / 2][i].first && row <= SPAN_TABLE[col / 2][i].last)
                code = int'(SPAN_TABLE[col / 2][i].color);
        end
        return code;
    endfunction

    function automatic logic [`COLOR_W-1:0] colorFor(int category, logic [`COLOR_W-1:0] bg);
        case (category)
            int'(sprite_pkg::CC_BLACK):  return `RGB_BLACK;
            int'(sprite_pkg::CC_PINK):   return `RGB_PINK;
            int'(sprite_pkg::CC_YELLOW): return `RGB_YELLOW;
            int'(sprite_pkg::CC_GREEN):  return `RGB_GREEN;
            default:                     return bg;
        endcase
    endfunction

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Test failures found");
            $fatal(1, "Stopped on first mismatch");
        end
    endtask

    task automatic stopRun(string reason);
        $display("%s at %0t ns", reason, $time);
        $display("Test failures found");
        $fatal(1, "Stopped on first failure");
    endtask

    task automatic sendPixel();
        int pick;
        int x;
        int y;
        int lx;
        int ty;
        int cat;
        logic [`COLOR_W-1:0] bg;
        pick = nextRand() % 8;
        lx = nextRand() % 78;
        ty = nextRand() % 70;
        if (pick < 6)
        begin
            x = lx + nextRand() % `SPRITE_W;
            y = ty + nextRand() % `SPRITE_H;
        end
        else if (pick == 6)
        begin
            // One column past the right edge
            x = lx + `SPRITE_W;
            y = ty + nextRand() % (`SPRITE_H + 1);
        end
        else
        begin
            x = nextRand() % 128;
            y = nextRand() % 128;
        end
        bg = `COLOR_W'(nextRand());
        cat = classify(x, y, lx, ty);
        seen[cat + 1] = 1'b1;
        expQ.push_back(colorFor(cat, bg));
        inValid <= 1'b1;
        inX <= `PIX_X_W'(x);
        inY <= `PIX_Y_W'(y);
        inLeftX <= `PIX_X_W'(lx);
        inTopY <= `PIX_Y_W'(ty);
        inBackground <= bg;
        sentCount++;
    endtask

    ////////////////////////////////////////
    // Sender and receiver
    ////////////////////////////////////////

    always @(posedge clk)
    begin
        inValid <= 1'b0;
        outCredit <= 1'b0;
        if (running)
        begin
            if (sentCount < NUM_PIXELS && senderCredits() > 0 && nextRand() % 4 != 0)
                sendPixel();
            if (stallLeft > 0)
            begin
                stallLeft--;
                stallAge++;
                if (stallLeft == 0)
                begin
                    if (sentCount < NUM_PIXELS && senderCredits() != 0)
                        stopRun("Sender still held credits after a long outCredit stall");
                    stallAge = 0;
                    stallsDone++;
                end
            end
            else if (stallsDone < STALL_COUNT && sentCount >= nextStallAt)
            begin
                // Withhold credits long enough to back up both FIFOs
                stallLeft = 150 + nextRand() % 100;
                nextStallAt += STALL_SPACING;
            end
            else if (recvCount > returnedCredits && nextRand() % 3 != 0)
            begin
                outCredit <= 1'b1;
                returnedCredits++;
            end
        end
    end

    // Outputs are stable mid-cycle
    always @(negedge clk)
    begin
        if (arstN)
        begin
            cycleCount++;
            if (cycleCount > TIMEOUT_CYCLES)
                stopRun("Timeout before every pixel came out");
            if (inCredit)
            begin
                creditPulses++;
                if (creditPulses > sentCount)
                    stopRun("inCredit pulsed more often than pixels were sent");
            end
            if (stallAge >= STALL_SETTLE)
                checkValue("inCredit", inCredit, 1'b0);
            if (outValid)
            begin
                recvCount++;
                if (recvCount > `OUT_CREDITS + returnedCredits)
                    stopRun("outValid beat beyond the credits granted");
                else if (expQ.size() == 0)
                    stopRun("Output beat with no pixel outstanding");
                else
                    checkValue("outColor", outColor, expQ.pop_front());
            end
        end
    end

    initial
    begin
        bit allSeen;
        clk = 1'b0;
        arstN = 1'b0;
        inValid = 1'b0;
        inX = '0;
        inY = '0;
        inLeftX = '0;
        inTopY = '0;
        inBackground = '0;
        outCredit = 1'b0;
        running = 1'b0;
        lcgState = 32'd97467;
        sentCount = 0;
        recvCount = 0;
        creditPulses = 0;
        returnedCredits = 0;
        cycleCount = 0;
        stallLeft = 0;
        stallAge = 0;
        stallsDone = 0;
        nextStallAt = 300;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
        // Quiet outputs before any pixel goes in
        repeat (5)
        begin
            @(negedge clk);
            checkValue("outValid", outValid, 1'b0);
            checkValue("inCredit", inCredit, 1'b0);
        end
        @(posedge clk);
        running <= 1'b1;
        while (recvCount < NUM_PIXELS)
            @(negedge clk);
        // Any extra beat is caught by the monitor
        repeat (20) @(negedge clk);
        checkValue("creditPulses", creditPulses, sentCount);
        checkValue("stallsDone", stallsDone, STALL_COUNT);
        allSeen = 1'b1;
        for (int i = 0; i < 7; i++)
            allSeen = allSeen & seen[i];
        if (allSeen)
        begin
            $display("All tests passed!");
            $finish;
        end
        else
        begin
            stopRun("Some colour codes never came up in the random pixels");
        end
    end

endmodule

// ==== verilog/pixel_egress.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"

module pixel_egress
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   pxValid,
    input  logic [`COLOR_W-1:0]    pxColor,
    input  logic                   outCredit,
    input  logic                   popped,
    output logic                   room,
    output logic                   outValid,
    output logic [`COLOR_W-1:0]    outColor
);

    localparam int PTR_W = $clog2(`OUT_DEPTH);
    localparam int CNT_W = $clog2(`OUT_DEPTH + 1);
    localparam int CREDIT_W = $clog2(`OUT_CREDITS + 1) + 1;

    logic [`COLOR_W-1:0] mem [`OUT_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] inFlight;
    logic [CREDIT_W-1:0] credits;
    logic send;

    assign send = (count != '0) && (credits != '0);
    assign outValid = send;
    assign outColor = mem[rdPtr];

    // Reserve a slot for every pixel still inside the shader
    assign room = (count + inFlight) < `OUT_DEPTH;

    always_ff @(posedge clk)
    begin
        if (pxValid)
            mem[wrPtr] <= pxColor;
    end

    ////////////////////////////////////////
    // FIFO pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (pxValid)
                wrPtr <= (wrPtr == PTR_W'(`OUT_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (send)
                rdPtr <= (rdPtr == PTR_W'(`OUT_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            case ({pxValid, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // In-flight pixels and downstream credits
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            inFlight <= '0;
            credits <= CREDIT_W'(`OUT_CREDITS);
        end
        else
        begin
            case ({popped, pxValid})
                2'b10:   inFlight <= inFlight + 1'b1;
                2'b01:   inFlight <= inFlight - 1'b1;
                default: inFlight <= inFlight;
            endcase
            case ({outCredit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== verilog/pixel_ingress.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"

module pixel_ingress
(
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       inValid,
    input  logic [`PIX_X_W-1:0]        inX,
    input  logic [`PIX_Y_W-1:0]        inY,
    input  logic [`PIX_X_W-1:0]        inLeftX,
    input  logic [`PIX_Y_W-1:0]        inTopY,
    input  logic [`COLOR_W-1:0]        inBackground,
    input  logic                       room,
    output logic                       inCredit,
    output logic                       shValid,
    output sprite_pkg::pixelItem_t     shItem
);

    localparam int PTR_W = $clog2(`IN_DEPTH);
    localparam int CNT_W = $clog2(`IN_DEPTH + 1);

    sprite_pkg::pixelItem_t mem [`IN_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic pop;

    // Head of queue goes out when egress has room for it
    assign shValid = (count != '0);
    assign shItem = mem[rdPtr];
    assign pop = shValid && room;

    // Each pop frees a slot for the sender
    assign inCredit = pop;

    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            mem[wrPtr] <= '{x: inX, y: inY, leftX: inLeftX, topY: inTopY,
                            background: inBackground};
        end
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (inValid)
                wrPtr <= (wrPtr == PTR_W'(`IN_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (pop)
                rdPtr <= (rdPtr == PTR_W'(`IN_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            case ({inValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/sprite_pkg.sv ====
`include "sprite_consts.svh"

package sprite_pkg;

    // Colour code of one span, CC_NONE marks an empty slot
    typedef enum logic [2:0]
    {
        CC_NONE,
        CC_BG,
        CC_BLACK,
        CC_PINK,
        CC_YELLOW,
        CC_GREEN
    } colorCode_e;

    // Row range inside the sprite and its colour
    typedef struct packed
    {
        logic [5:0] first;
        logic [5:0] last;
        colorCode_e color;
    } span_t;

    // One screen pixel with the sprite origin it is drawn against
    typedef struct packed
    {
        logic [`PIX_X_W-1:0] x;
        logic [`PIX_Y_W-1:0] y;
        logic [`PIX_X_W-1:0] leftX;
        logic [`PIX_Y_W-1:0] topY;
        logic [`COLOR_W-1:0] background;
    } pixelItem_t;

endpackage

// ==== verilog/sprite_shader.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"
`include "strawberry_spans.svh"

module sprite_shader
(
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       shValid,
    input  sprite_pkg::pixelItem_t     shItem,
    output logic                       pxValid,
    output logic [`COLOR_W-1:0]        pxColor
);

    localparam int PAIR_W = $clog2(`COL_PAIRS);

    localparam sprite_pkg::span_t SPANS [`COL_PAIRS][`SPANS_PER_PAIR] = `STRAWBERRY_SPANS;

    logic [`PIX_X_W-1:0] colOff;
    logic [`PIX_Y_W-1:0] rowOff;
    logic inBox;

    logic s1Valid;
    logic s1InBox;
    logic [PAIR_W-1:0] s1Pair;
    logic [5:0] s1Row;
    logic [`COLOR_W-1:0] s1Bg;

    sprite_pkg::colorCode_e hitCode;
    logic [`COLOR_W-1:0] color;

    ////////////////////////////////////////
    // Stage 1, sprite-space offsets
    ////////////////////////////////////////

    assign colOff = shItem.x - shItem.leftX;
    assign rowOff = shItem.y - shItem.topY;
    assign inBox = (shItem.x >= shItem.leftX) && (colOff < `SPRITE_W) &&
                   (shItem.y >= shItem.topY) && (rowOff < `SPRITE_H);

    always_ff @(posedge clk)
    begin
        s1InBox <= inBox;
        // Both columns of a pair share one span list
        s1Pair <= inBox ? colOff[PAIR_W:1] : '0;
        s1Row <= rowOff[5:0];
        s1Bg <= shItem.background;
    end

    ////////////////////////////////////////
    // Stage 2, span match and palette
    ////////////////////////////////////////

    // First matching slot wins
    always_comb
    begin
        logic found;
        found = 1'b0;
        hitCode = sprite_pkg::CC_NONE;
        for (int i = 0; i < `SPANS_PER_PAIR; i++)
        begin
            if (!found && SPANS[s1Pair][i].color != sprite_pkg::CC_NONE &&
                s1Row >= SPANS[s1Pair][i].first && s1Row <= SPANS[s1Pair][i].last)
            begin
                found = 1'b1;
                hitCode = SPANS[s1Pair][i].color;
            end
        end
    end

    always_comb
    begin
        case (hitCode)
            sprite_pkg::CC_BLACK:  color = `RGB_BLACK;
            sprite_pkg::CC_PINK:   color = `RGB_PINK;
            sprite_pkg::CC_YELLOW: color = `RGB_YELLOW;
            sprite_pkg::CC_GREEN:  color = `RGB_GREEN;
            default:               color = s1Bg;
        endcase
    end

    always_ff @(posedge clk)
    begin
        pxColor <= s1InBox ? color : s1Bg;
    end

    // Valid bits of both stages
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            s1Valid <= 1'b0;
            pxValid <= 1'b0;
        end
        else
        begin
            s1Valid <= shValid;
            pxValid <= s1Valid;
        end
    end

endmodule

// ==== verilog/strawberry_sprite_top.sv ====
`timescale 1ns/1ps
`include "sprite_consts.svh"

module strawberry_sprite_top
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   inValid,
    input  logic [`PIX_X_W-1:0]    inX,
    input  logic [`PIX_Y_W-1:0]    inY,
    input  logic [`PIX_X_W-1:0]    inLeftX,
    input  logic [`PIX_Y_W-1:0]    inTopY,
    input  logic [`COLOR_W-1:0]    inBackground,
    output logic                   inCredit,
    output logic                   outValid,
    output logic [`COLOR_W-1:0]    outColor,
    input  logic                   outCredit
);

    logic shValid;
    sprite_pkg::pixelItem_t shItem;
    logic room;
    logic popped;
    logic pxValid;
    logic [`COLOR_W-1:0] pxColor;

    // Head leaves ingress only when egress can take it later
    assign popped = shValid & room;

    pixel_ingress ingress
    (
        .clk(clk),
        .arstN(arstN),
        .inValid(inValid),
        .inX(inX),
        .inY(inY),
        .inLeftX(inLeftX),
        .inTopY(inTopY),
        .inBackground(inBackground),
        .room(room),
        .inCredit(inCredit),
        .shValid(shValid),
        .shItem(shItem)
    );

    sprite_shader shader
    (
        .clk(clk),
        .arstN(arstN),
        .shValid(popped),
        .shItem(shItem),
        .pxValid(pxValid),
        .pxColor(pxColor)
    );

    pixel_egress egress
    (
        .clk(clk),
        .arstN(arstN),
        .pxValid(pxValid),
        .pxColor(pxColor),
        .outCredit(outCredit),
        .popped(popped),
        .room(room),
        .outValid(outValid),
        .outColor(outColor)
    );

endmodule
